// File: hw/kdf11_pkg.sv
// Shared definitions for the KDF11 I/O page slave.
// Address map, bus widths, arbiter states and timing constants.
// Every RTL file reaches these through kdf11_pkg:: scoped names.

`default_nettype none

package kdf11_pkg;

  // ****************************************
  // bus widths
  // ****************************************
  typedef logic [21:0] addr22_t;     // 22-bit physical address
  typedef logic [17:0] uadr18_t;     // unibus dma address
  typedef logic [15:0] word_t;       // data word
  typedef logic [1:0]  sel_t;        // byte select, bit 0 = low byte
  typedef logic [21:1] umap_base_t;  // map base, physical bits 21:1

  // dma arbiter, who owns the memory bus
  typedef enum logic {
    CPU_OWNS = 1'b0,
    DMA_OWNS = 1'b1
  } dma_state_t;

  // ****************************************
  // i/o page address map (octal)
  // ****************************************
  localparam logic [15:0] LKS_ADR       = 16'o177546;  // line clock status
  localparam logic [15:0] BDR_BASE      = 16'o177520;  // pcr, maint, cdr
  localparam logic [15:0] UMAP_BASE     = 16'o170200;  // map window 170200-170377
  localparam logic [5:0]  UMAP_WIN_BITS = 6'b100001;   // adr bits 12:7 of the window

  // ****************************************
  // sizes and timing
  // ****************************************
  localparam int UMAP_REGS      = 32;    // map registers
  localparam int UMAP_PAGE_BITS = 13;    // 8 kB page offset
  localparam int LTC_PERIOD     = 1000;  // clocks per line clock tick
  localparam int LTC_CNT_W      = $clog2(LTC_PERIOD);

  // terminal count of the tick divider
  localparam logic [LTC_CNT_W-1:0] LTC_LAST = LTC_CNT_W'(LTC_PERIOD - 1);

  localparam logic [7:0] CDR_SWITCHES = 8'h08;  // board switch image read at cdr

endpackage

`default_nettype wire

// File: hw/iopage_ctrl.sv
// Bus control for the I/O page slave.
// Decodes the CPU address, runs the four-phase acknowledge, muxes read data,
// and arbitrates the memory bus between the CPU and DMA masters.

`timescale 1ns/1ps
`default_nettype none

module iopage_ctrl (
  input  wire                      clk_p,
  input  wire                      dclo,
  // cpu master
  input  wire kdf11_pkg::addr22_t  cpu_adr_i,
  input  wire                      cpu_ios_i,    // cycle is in the i/o page
  input  wire                      cpu_we_i,
  input  wire                      cpu_stb_i,    // four-phase request
  output logic                     cpu_ack_o,
  output kdf11_pkg::word_t         cpu_dat_o,
  // dma master
  input  wire                      dma_req_i,
  input  wire                      dma_stb_i,
  output logic                     dma_ack_o,
  input  wire kdf11_pkg::addr22_t  dma_adr_i,    // translated by the map
  // external memory and bus
  input  wire                      global_ack_i,
  input  wire kdf11_pkg::word_t    ext_dat_i,
  output logic                     ram_stb_o,
  output logic                     bus_stb_o,
  output kdf11_pkg::addr22_t       mem_adr_o,
  // internal devices
  input  wire kdf11_pkg::word_t    ltc_dat_i,
  input  wire kdf11_pkg::word_t    bdr_dat_i,
  input  wire kdf11_pkg::word_t    umap_dat_i,
  output logic                     ltc_sel_o,
  output logic                     bdr_sel_o,
  output logic                     umap_sel_o,
  output logic                     wr_stb_o      // one clock per write cycle
);

  kdf11_pkg::dma_state_t dma_state;
  logic                  dma_own;   // dma holds the bus
  logic                  dev_hit;   // an internal device claims the cycle
  logic                  dev_cyc;   // claimed cycle may proceed
  logic                  ack_q;     // acknowledge flop for internal devices

  // ****************************************
  // address decode
  // ****************************************
  assign ltc_sel_o  = cpu_ios_i & (cpu_adr_i[15:1] == kdf11_pkg::LKS_ADR[15:1]);
  assign bdr_sel_o  = cpu_ios_i & (cpu_adr_i[15:3] == kdf11_pkg::BDR_BASE[15:3]);
  assign umap_sel_o = cpu_ios_i
                    & (cpu_adr_i[15:13] == kdf11_pkg::UMAP_BASE[15:13])
                    & (cpu_adr_i[12:7] == kdf11_pkg::UMAP_WIN_BITS);  // 170200-170377

  assign dev_hit = ltc_sel_o | bdr_sel_o | umap_sel_o;
  assign dma_own = (dma_state == kdf11_pkg::DMA_OWNS);
  assign dev_cyc = cpu_stb_i & dev_hit & ~dma_own;  // cpu waits while dma owns

  // write lands on the first request cycle only, ack is still low there
  assign wr_stb_o = dev_cyc & cpu_we_i & ~ack_q;

  // ****************************************
  // four-phase acknowledge
  // ****************************************
  always_ff @(posedge clk_p or posedge dclo) begin
    if (dclo) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= dev_cyc;  // follows the request one clock late
    end
  end

  // internal devices answer from the flop, everything else from the outside
  assign cpu_ack_o = dev_hit ? ack_q : (global_ack_i & ~dma_own);

  // ****************************************
  // dma arbiter
  // ****************************************
  always_ff @(posedge clk_p or posedge dclo) begin
    if (dclo) begin
      dma_state <= kdf11_pkg::CPU_OWNS;
    end else begin
      case (dma_state)
        kdf11_pkg::CPU_OWNS:
          if (dma_req_i && !cpu_stb_i) dma_state <= kdf11_pkg::DMA_OWNS;  // bus idle
        kdf11_pkg::DMA_OWNS:
          if (!dma_req_i) dma_state <= kdf11_pkg::CPU_OWNS;
        default: dma_state <= kdf11_pkg::CPU_OWNS;
      endcase
    end
  end

  assign dma_ack_o = dma_own;

  // external strobes, dma drives memory directly
  assign ram_stb_o = dma_own ? dma_stb_i : (cpu_stb_i & ~cpu_ios_i);
  assign bus_stb_o = ~dma_own & cpu_stb_i & cpu_ios_i & ~dev_hit;  // unclaimed i/o
  assign mem_adr_o = dma_own ? dma_adr_i : cpu_adr_i;

  // read data mux
  always_comb begin
    cpu_dat_o = ext_dat_i;  // memory and external bus
    if (ltc_sel_o) begin
      cpu_dat_o = ltc_dat_i;
    end else if (bdr_sel_o) begin
      cpu_dat_o = bdr_dat_i;
    end else if (umap_sel_o) begin
      cpu_dat_o = umap_dat_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/ltc_timer.sv
// Line time clock with its LKS status register.
// A free-running divider makes a one-clock tick every LTC_PERIOD clocks,
// which becomes an interrupt event while the enable bit is set.

`timescale 1ns/1ps
`default_nettype none

module ltc_timer (
  input  wire                    clk_p,
  input  wire                    dclo,
  input  wire                    sel_i,       // lks addressed
  input  wire                    wr_stb_i,    // write edge
  input  wire kdf11_pkg::word_t  wr_dat_i,
  output kdf11_pkg::word_t       rd_dat_o,
  output logic                   evnt_o,      // interrupt event pulse
  output logic                   led_timer_o  // lit while the clock is off
);

  logic [kdf11_pkg::LTC_CNT_W-1:0] div_cnt;
  logic                            tick;     // one clock per period
  logic                            ltc_ie;   // lks bit 6
  logic                            ltc_mon;  // lks bit 7

  // ****************************************
  // tick divider
  // ****************************************
  always_ff @(posedge clk_p or posedge dclo) begin
    if (dclo) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if (div_cnt == kdf11_pkg::LTC_LAST) begin
      div_cnt <= '0;    // wrap
      tick    <= 1'b1;
    end else begin
      div_cnt <= div_cnt + kdf11_pkg::LTC_CNT_W'(1);
      tick    <= 1'b0;
    end
  end

  // ****************************************
  // lks register
  // ****************************************
  always_ff @(posedge clk_p or posedge dclo) begin
    if (dclo) begin
      ltc_ie  <= 1'b0;
      ltc_mon <= 1'b1;  // reads 0080 after reset
    end else if (sel_i && wr_stb_i) begin
      ltc_ie <= wr_dat_i[6];
      if (!wr_dat_i[7]) ltc_mon <= 1'b0;  // only a 0 clears the monitor
    end else if (tick && !ltc_ie) begin
      ltc_mon <= 1'b1;  // software polls this with interrupts off
    end
  end

  assign rd_dat_o    = {8'h00, ltc_mon, ltc_ie, 6'b000000};
  assign evnt_o      = tick & ltc_ie;
  assign led_timer_o = ~ltc_ie;

endmodule

`default_nettype wire

// File: hw/bdr_regs.sv
// Boot and diagnostic registers at 177520-177526.
// PCR and the maintenance word are plain storage; the CDR reads the board
// switches and drives the four diagnostic LEDs on write.

`timescale 1ns/1ps
`default_nettype none

module bdr_regs (
  input  wire                    clk_p,
  input  wire                    dclo,
  input  wire                    sel_i,        // bdr block addressed
  input  wire                    wr_stb_i,
  input  wire [1:0]              adr_i,        // word offset, adr bits 2:1
  input  wire kdf11_pkg::sel_t   sel_bytes_i,
  input  wire kdf11_pkg::word_t  wr_dat_i,
  output kdf11_pkg::word_t       rd_dat_o,
  output logic [3:0]             cdr_o         // led drive
);

  logic [3:0]       pcr_l;     // pcr bits 3:0
  logic [3:0]       pcr_h;     // pcr bits 11:8
  kdf11_pkg::word_t bd_maint;  // scratch word for diagnostics

  // ****************************************
  // register writes
  // ****************************************
  always_ff @(posedge clk_p or posedge dclo) begin
    if (dclo) begin
      pcr_l    <= 4'h0;
      pcr_h    <= 4'h0;
      bd_maint <= '0;
      cdr_o    <= 4'h0;
    end else if (sel_i && wr_stb_i) begin
      case (adr_i)
        2'd0: begin  // pcr, one nibble per byte lane
          if (sel_bytes_i[0]) pcr_l <= wr_dat_i[3:0];
          if (sel_bytes_i[1]) pcr_h <= wr_dat_i[11:8];
        end
        2'd1: begin  // maintenance
          if (sel_bytes_i[0]) bd_maint[7:0]  <= wr_dat_i[7:0];
          if (sel_bytes_i[1]) bd_maint[15:8] <= wr_dat_i[15:8];
        end
        2'd2: if (sel_bytes_i[0]) cdr_o <= wr_dat_i[3:0];  // cdr leds
        default: ;  // offset 3 ignores writes
      endcase
    end
  end

  // read back, combinational
  always_comb begin
    case (adr_i)
      2'd0:    rd_dat_o = {4'h0, pcr_h, 4'h0, pcr_l};
      2'd1:    rd_dat_o = bd_maint;
      2'd2:    rd_dat_o = {8'h00, kdf11_pkg::CDR_SWITCHES};  // switch image
      default: rd_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/umap_regs.sv
// Unibus map: 32 base registers in the 170200-170377 window.
// Each register pair holds a 22-bit page base; DMA addresses pick a register
// with their top five bits and add the 13-bit page offset to its base.

`timescale 1ns/1ps
`default_nettype none

module umap_regs (
  input  wire                     clk_p,
  input  wire                     sel_i,         // map window addressed
  input  wire                     wr_stb_i,
  input  wire [6:1]               adr_i,         // 6:2 register, 1 high word
  input  wire kdf11_pkg::sel_t    sel_bytes_i,
  input  wire kdf11_pkg::word_t   wr_dat_i,
  input  wire kdf11_pkg::uadr18_t dma_adr18_i,
  input  wire                     umap_en_i,     // mapping on
  output kdf11_pkg::word_t        rd_dat_o,
  output kdf11_pkg::addr22_t      dma_adr_o
);

  kdf11_pkg::umap_base_t                     map_q [kdf11_pkg::UMAP_REGS];
  logic [$clog2(kdf11_pkg::UMAP_REGS)-1:0]   cpu_idx;   // register on cpu side
  logic [$clog2(kdf11_pkg::UMAP_REGS)-1:0]   dma_idx;   // register on dma side
  kdf11_pkg::umap_base_t                     cpu_ent;
  kdf11_pkg::umap_base_t                     dma_ent;
  kdf11_pkg::addr22_t                        page_base;
  kdf11_pkg::addr22_t                        page_off;

  assign cpu_idx = adr_i[6:2];
  assign cpu_ent = map_q[cpu_idx];

  // ****************************************
  // register file
  // ****************************************
  always_ff @(posedge clk_p) begin
    if (sel_i && wr_stb_i) begin
      if (!adr_i[1]) begin
        // low word, bit 0 is not stored
        if (sel_bytes_i[0]) map_q[cpu_idx][7:1]  <= wr_dat_i[7:1];
        if (sel_bytes_i[1]) map_q[cpu_idx][15:8] <= wr_dat_i[15:8];
      end else begin
        if (sel_bytes_i[0]) map_q[cpu_idx][21:16] <= wr_dat_i[5:0];  // high bits
      end
    end
  end

  // cpu read
  always_comb begin
    if (!adr_i[1]) begin
      rd_dat_o = {cpu_ent[15:1], 1'b0};
    end else begin
      rd_dat_o = {10'h000, cpu_ent[21:16]};
    end
  end

  // ****************************************
  // dma address translation
  // ****************************************
  assign dma_idx   = dma_adr18_i[17:kdf11_pkg::UMAP_PAGE_BITS];
  assign dma_ent   = map_q[dma_idx];
  assign page_base = {dma_ent, 1'b0};  // word aligned base
  assign page_off  = kdf11_pkg::addr22_t'(dma_adr18_i[kdf11_pkg::UMAP_PAGE_BITS-1:0]);

  always_comb begin
    if (umap_en_i) begin
      dma_adr_o = page_base + page_off;
    end else begin
      dma_adr_o = kdf11_pkg::addr22_t'(dma_adr18_i);  // straight 18-bit
    end
  end

endmodule

`default_nettype wire

// File: hw/kdf11_iopage.sv
// Top level of the KDF11 I/O page slave.
// The CPU master port, external memory side and DMA side come in here;
// the control block routes cycles to the clock, BDR and map blocks.

`timescale 1ns/1ps
`default_nettype none

module kdf11_iopage (
  input  wire                     clk_p,
  input  wire                     dclo,
  // cpu master
  input  wire kdf11_pkg::addr22_t cpu_adr_i,
  input  wire                     cpu_ios_i,
  input  wire                     cpu_we_i,
  input  wire kdf11_pkg::sel_t    cpu_sel_i,
  input  wire kdf11_pkg::word_t   cpu_dat_i,
  input  wire                     cpu_stb_i,
  output logic                    cpu_ack_o,
  output kdf11_pkg::word_t        cpu_dat_o,
  // external side
  output kdf11_pkg::addr22_t      mem_adr_o,
  output logic                    ram_stb_o,
  output logic                    bus_stb_o,
  input  wire kdf11_pkg::word_t   ext_dat_i,
  input  wire                     global_ack_i,
  // dma side
  input  wire                     dma_req_i,
  output logic                    dma_ack_o,
  input  wire kdf11_pkg::uadr18_t dma_adr18_i,
  input  wire                     dma_stb_i,
  input  wire                     umap_en_i,
  // status
  output logic                    ltc_evnt_o,
  output logic                    led_timer_o,
  output logic [3:0]              cdr_o
);

  kdf11_pkg::word_t   ltc_dat;
  kdf11_pkg::word_t   bdr_dat;
  kdf11_pkg::word_t   umap_dat;
  kdf11_pkg::addr22_t dma_adr;   // mapped dma address
  logic               ltc_sel;
  logic               bdr_sel;
  logic               umap_sel;
  logic               wr_stb;

  iopage_ctrl i_iopage_ctrl (
    .clk_p        (clk_p),        .dclo        (dclo),
    .cpu_adr_i    (cpu_adr_i),    .cpu_ios_i   (cpu_ios_i),
    .cpu_we_i     (cpu_we_i),     .cpu_stb_i   (cpu_stb_i),
    .cpu_ack_o    (cpu_ack_o),    .cpu_dat_o   (cpu_dat_o),
    .dma_req_i    (dma_req_i),    .dma_stb_i   (dma_stb_i),
    .dma_ack_o    (dma_ack_o),    .dma_adr_i   (dma_adr),
    .global_ack_i (global_ack_i), .ext_dat_i   (ext_dat_i),
    .ram_stb_o    (ram_stb_o),    .bus_stb_o   (bus_stb_o),
    .mem_adr_o    (mem_adr_o),
    .ltc_dat_i    (ltc_dat),      .bdr_dat_i   (bdr_dat),
    .umap_dat_i   (umap_dat),
    .ltc_sel_o    (ltc_sel),      .bdr_sel_o   (bdr_sel),
    .umap_sel_o   (umap_sel),     .wr_stb_o    (wr_stb)
  );

  ltc_timer i_ltc_timer (
    .clk_p (clk_p), .dclo (dclo), .sel_i (ltc_sel), .wr_stb_i (wr_stb),
    .wr_dat_i (cpu_dat_i), .rd_dat_o (ltc_dat),
    .evnt_o (ltc_evnt_o), .led_timer_o (led_timer_o)
  );

  bdr_regs i_bdr_regs (
    .clk_p (clk_p), .dclo (dclo), .sel_i (bdr_sel), .wr_stb_i (wr_stb),
    .adr_i (cpu_adr_i[2:1]), .sel_bytes_i (cpu_sel_i),
    .wr_dat_i (cpu_dat_i), .rd_dat_o (bdr_dat), .cdr_o (cdr_o)
  );

  umap_regs i_umap_regs (
    .clk_p (clk_p), .sel_i (umap_sel), .wr_stb_i (wr_stb),
    .adr_i (cpu_adr_i[6:1]), .sel_bytes_i (cpu_sel_i), .wr_dat_i (cpu_dat_i),
    .dma_adr18_i (dma_adr18_i), .umap_en_i (umap_en_i),
    .rd_dat_o (umap_dat), .dma_adr_o (dma_adr)
  );

endmodule

`default_nettype wire

// File: tb/kdf11_iopage_asserts.sv
// Concurrent checks on the CPU handshake and DMA bus ownership.
// Bound into kdf11_iopage by the bind statement at the end of this file.

`timescale 1ns/1ps
`default_nettype none

module kdf11_iopage_asserts (
  input wire clk_p,
  input wire dclo,
  input wire cpu_stb_i,
  input wire cpu_ack_o,
  input wire global_ack_i,
  input wire dma_ack_o,
  input wire dma_stb_i,
  input wire ram_stb_o
);

  // ****************************************
  // handshake
  // ****************************************
  ack_needs_req: assert property (@(posedge clk_p) disable iff (dclo)
    cpu_ack_o |-> ($past(cpu_stb_i) || global_ack_i))
    else $error("cpu_ack_o high with no request the cycle before");

  // one owner at a time
  one_owner: assert property (@(posedge clk_p) disable iff (dclo)
    !(cpu_ack_o && dma_ack_o))
    else $error("cpu_ack_o and dma_ack_o high together");

  dma_strobe: assert property (@(posedge clk_p) disable iff (dclo)
    dma_ack_o |-> (ram_stb_o == dma_stb_i))  // dma drives memory directly
    else $error("ram_stb_o does not follow dma_stb_i during dma");

endmodule

bind kdf11_iopage kdf11_iopage_asserts i_asserts (
  .clk_p (clk_p), .dclo (dclo), .cpu_stb_i (cpu_stb_i), .cpu_ack_o (cpu_ack_o),
  .global_ack_i (global_ack_i), .dma_ack_o (dma_ack_o), .dma_stb_i (dma_stb_i),
  .ram_stb_o (ram_stb_o)
);

`default_nettype wire

// File: tb/tb_kdf11_iopage.sv
// Testbench for the KDF11 I/O page slave.
// Plays the CPU master, the DMA master and the external memory, then checks
// registers, map translation, bus arbitration, line clock and routing.

`timescale 1ns/1ps
`default_nettype none

module tb_kdf11_iopage;

  localparam int WAIT_MAX = 64;  // cycles a handshake may take

  logic               clk_p;
  logic               dclo;
  kdf11_pkg::addr22_t cpu_adr;
  logic               cpu_ios;
  logic               cpu_we;
  kdf11_pkg::sel_t    cpu_sel;
  kdf11_pkg::word_t   cpu_dat;
  logic               cpu_stb;
  logic               cpu_ack;
  kdf11_pkg::word_t   cpu_rdat;
  kdf11_pkg::addr22_t mem_adr;
  logic               ram_stb;
  logic               bus_stb;
  kdf11_pkg::word_t   ext_dat = 16'h0000;
  logic               global_ack = 1'b0;
  logic               dma_req;
  logic               dma_ack;
  kdf11_pkg::uadr18_t dma_adr18;
  logic               dma_stb;
  logic               umap_en;
  logic               ltc_evnt;
  logic               led_timer;
  logic [3:0]         cdr;

  kdf11_pkg::word_t      ext_word = 16'h0000;  // external memory answer
  kdf11_pkg::umap_base_t map_model [kdf11_pkg::UMAP_REGS];
  kdf11_pkg::word_t      pcr_exp;
  kdf11_pkg::word_t      maint_exp;
  kdf11_pkg::word_t      rd;
  kdf11_pkg::word_t      wd;
  kdf11_pkg::sel_t       sel;
  kdf11_pkg::uadr18_t    da;
  logic [4:0]            ri;
  logic                  en_map;
  logic [31:0]           lcg_state = 32'hd120185e;
  int                    cyc = 0;
  int                    t0;
  int                    t_first;
  int                    t_second;
  int                    n_checks = 0;
  int                    n_errors = 0;
  int                    n_timeouts = 0;

  kdf11_iopage i_kdf11_iopage (
    .clk_p        (clk_p),      .dclo        (dclo),
    .cpu_adr_i    (cpu_adr),    .cpu_ios_i   (cpu_ios),
    .cpu_we_i     (cpu_we),     .cpu_sel_i   (cpu_sel),
    .cpu_dat_i    (cpu_dat),    .cpu_stb_i   (cpu_stb),
    .cpu_ack_o    (cpu_ack),    .cpu_dat_o   (cpu_rdat),
    .mem_adr_o    (mem_adr),    .ram_stb_o   (ram_stb),
    .bus_stb_o    (bus_stb),    .ext_dat_i   (ext_dat),
    .global_ack_i (global_ack), .dma_req_i   (dma_req),
    .dma_ack_o    (dma_ack),    .dma_adr18_i (dma_adr18),
    .dma_stb_i    (dma_stb),    .umap_en_i   (umap_en),
    .ltc_evnt_o   (ltc_evnt),   .led_timer_o (led_timer),
    .cdr_o        (cdr)
  );

  initial begin
    clk_p = 1'b0;
    forever #20 clk_p = ~clk_p;  // 40 ns
  end

  always @(posedge clk_p) cyc <= cyc + 1;  // posedge count for timing checks

  // external memory / bus, answers one clock after a cpu strobe
  always @(posedge clk_p) begin
    global_ack <= bus_stb | (ram_stb & ~dma_ack);
    ext_dat    <= ext_word;
  end

  // ****************************************
  // reference and helpers
  // ****************************************
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected dma address, page base from the model plus 13-bit offset
  function automatic kdf11_pkg::addr22_t ref_umap_adr(input kdf11_pkg::uadr18_t a,
                                                      input logic en);
    kdf11_pkg::addr22_t base;
    if (!en) return {4'h0, a};  // map off, plain 18 bits
    base = {map_model[a[17:13]], 1'b0};
    return base + {9'h000, a[12:0]};
  endfunction

  function automatic kdf11_pkg::addr22_t io_adr(input kdf11_pkg::word_t a);
    return {6'h3f, a};  // top of the 22-bit space
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s got=%h exp=%h", name, got, exp);
    end
  endtask

  // poll an acknowledge at the falling edge, bounded
  task automatic wait_ack(input logic is_dma, input logic level, input string what);
    int n = 0;
    @(negedge clk_p);
    while (((is_dma ? dma_ack : cpu_ack) !== level) && n < WAIT_MAX) begin
      @(negedge clk_p);
      n++;
    end
    if ((is_dma ? dma_ack : cpu_ack) !== level) begin
      n_timeouts++;
      $display("timeout: acknowledge never went to %0d during %s", level, what);
    end
  endtask

  // next ltc_evnt_o pulse, returns the cycle it was seen in
  task automatic wait_event(output int at);
    int n = 0;
    @(negedge clk_p);
    while (ltc_evnt !== 1'b1 && n < kdf11_pkg::LTC_PERIOD + 2) begin
      @(negedge clk_p);
      n++;
    end
    if (ltc_evnt !== 1'b1) begin
      n_timeouts++;
      $display("timeout: no line clock event within one period");
    end
    at = cyc;
  endtask

  // ****************************************
  // four-phase cpu cycles
  // ****************************************
  task automatic bus_request(input kdf11_pkg::addr22_t adr, input logic ios, input logic we,
                             input kdf11_pkg::sel_t bsel, input kdf11_pkg::word_t dat);
    @(posedge clk_p);
    cpu_adr <= adr;
    cpu_ios <= ios;
    cpu_we  <= we;
    cpu_sel <= bsel;
    cpu_dat <= dat;
    cpu_stb <= 1'b1;
  endtask

  task automatic bus_complete(output kdf11_pkg::word_t dat);
    wait_ack(1'b0, 1'b1, "cpu request");
    dat = cpu_rdat;  // valid while ack is high
    @(posedge clk_p);
    cpu_stb <= 1'b0;
    cpu_we  <= 1'b0;
    wait_ack(1'b0, 1'b0, "cpu release");
  endtask

  task automatic cpu_write(input kdf11_pkg::word_t adr, input kdf11_pkg::sel_t bsel,
                           input kdf11_pkg::word_t dat);
    kdf11_pkg::word_t discard;
    bus_request(io_adr(adr), 1'b1, 1'b1, bsel, dat);
    bus_complete(discard);
  endtask

  task automatic cpu_read(input kdf11_pkg::word_t adr, output kdf11_pkg::word_t dat);
    bus_request(io_adr(adr), 1'b1, 1'b0, 2'b11, 16'h0000);
    bus_complete(dat);
  endtask

  // ****************************************
  // test sequence
  // ****************************************
  initial begin
    dclo      = 1'b1;
    cpu_adr   = '0;
    cpu_ios   = 1'b0;
    cpu_we    = 1'b0;
    cpu_sel   = 2'b00;
    cpu_dat   = '0;
    cpu_stb   = 1'b0;
    dma_req   = 1'b0;
    dma_adr18 = '0;
    dma_stb   = 1'b0;
    umap_en   = 1'b0;
    repeat (5) @(posedge clk_p);
    dclo <= 1'b0;

    // reset state
    @(negedge clk_p);
    check_equal("dma_ack_o", 32'(dma_ack), 32'h0);
    check_equal("cpu_ack_o", 32'(cpu_ack), 32'h0);
    check_equal("cdr_o", 32'(cdr), 32'h0);
    check_equal("led_timer_o", 32'(led_timer), 32'h1);
    cpu_read(kdf11_pkg::LKS_ADR, rd);
    check_equal("lks", 32'(rd), 32'h0080);
    cpu_read(kdf11_pkg::BDR_BASE, rd);
    check_equal("pcr", 32'(rd), 32'h0);
    cpu_read(kdf11_pkg::BDR_BASE + 16'd2, rd);
    check_equal("maint", 32'(rd), 32'h0);

    // boot/diagnostic registers, byte lanes from the lcg
    pcr_exp   = '0;
    maint_exp = '0;
    repeat (6) begin
      wd  = 16'(lcg_next() >> 16);
      sel = 2'(lcg_next() >> 20);
      cpu_write(kdf11_pkg::BDR_BASE, sel, wd);
      if (sel[0]) pcr_exp[3:0] = wd[3:0];    // low nibble only
      if (sel[1]) pcr_exp[11:8] = wd[11:8];
      wd  = 16'(lcg_next() >> 16);
      sel = 2'(lcg_next() >> 20);
      cpu_write(kdf11_pkg::BDR_BASE + 16'd2, sel, wd);
      if (sel[0]) maint_exp[7:0] = wd[7:0];
      if (sel[1]) maint_exp[15:8] = wd[15:8];
      cpu_read(kdf11_pkg::BDR_BASE, rd);
      check_equal("pcr", 32'(rd), 32'(pcr_exp));
      cpu_read(kdf11_pkg::BDR_BASE + 16'd2, rd);
      check_equal("maint", 32'(rd), 32'(maint_exp));
    end
    cpu_read(kdf11_pkg::BDR_BASE + 16'd4, rd);
    check_equal("cdr switches", 32'(rd), 32'(kdf11_pkg::CDR_SWITCHES));
    wd = 16'(lcg_next() >> 16);
    cpu_write(kdf11_pkg::BDR_BASE + 16'd4, 2'b01, wd);
    check_equal("cdr_o", 32'(cdr), 32'(wd[3:0]));

    // map register file, low then high word of each entry
    for (int i = 0; i < kdf11_pkg::UMAP_REGS; i++) begin
      ri = 5'(i);
      wd = 16'(lcg_next() >> 16);
      cpu_write(kdf11_pkg::UMAP_BASE + {9'h000, ri, 2'b00}, 2'b11, wd);
      map_model[ri][15:1] = wd[15:1];
      wd = 16'(lcg_next() >> 16);
      cpu_write(kdf11_pkg::UMAP_BASE + {9'h000, ri, 2'b10}, 2'b11, wd);
      map_model[ri][21:16] = wd[5:0];  // upper byte dropped
    end
    for (int i = 0; i < kdf11_pkg::UMAP_REGS; i++) begin
      ri = 5'(i);
      cpu_read(kdf11_pkg::UMAP_BASE + {9'h000, ri, 2'b00}, rd);
      check_equal("umap low", 32'(rd), 32'({map_model[ri][15:1], 1'b0}));
      cpu_read(kdf11_pkg::UMAP_BASE + {9'h000, ri, 2'b10}, rd);
      check_equal("umap high", 32'(rd), 32'({10'h000, map_model[ri][21:16]}));
    end

    // dma translation, map on then off
    for (int e = 0; e < 2; e++) begin
      en_map = (e == 0);
      repeat (8) begin
        da = 18'(lcg_next() >> 14);
        @(posedge clk_p);
        umap_en   <= en_map;
        dma_adr18 <= da;
        dma_req   <= 1'b1;
        dma_stb   <= 1'b1;
        wait_ack(1'b1, 1'b1, "dma grant");
        check_equal("mem_adr_o", 32'(mem_adr), 32'(ref_umap_adr(da, en_map)));
        check_equal("ram_stb_o", 32'(ram_stb), 32'h1);
        @(posedge clk_p);
        dma_req <= 1'b0;
        dma_stb <= 1'b0;
        wait_ack(1'b1, 1'b0, "dma release");
      end
    end

    // cpu request held off while dma owns the bus
    @(posedge clk_p);
    dma_req <= 1'b1;
    wait_ack(1'b1, 1'b1, "dma grant");
    bus_request(io_adr(kdf11_pkg::LKS_ADR), 1'b1, 1'b0, 2'b11, 16'h0000);
    repeat (6) begin
      @(negedge clk_p);
      check_equal("cpu_ack_o during dma", 32'(cpu_ack), 32'h0);
    end
    @(posedge clk_p);
    dma_req <= 1'b0;
    wait_ack(1'b1, 1'b0, "dma release");
    bus_complete(rd);  // cpu gets through once dma is gone

    // line clock events, two ticks one period apart
    cpu_write(kdf11_pkg::LKS_ADR, 2'b11, 16'h0040);
    check_equal("led_timer_o", 32'(led_timer), 32'h0);
    wait_event(t_first);
    wait_event(t_second);
    check_equal("ltc_evnt_o period", 32'(t_second - t_first), 32'(kdf11_pkg::LTC_PERIOD));

    // monitor bit, cleared right after a tick, set by the next one
    cpu_write(kdf11_pkg::LKS_ADR, 2'b11, 16'h0000);
    t0 = cyc;
    cpu_read(kdf11_pkg::LKS_ADR, rd);
    check_equal("lks monitor clear", 32'(rd[7]), 32'h0);
    while (rd[7] !== 1'b1 && (cyc - t0) <= kdf11_pkg::LTC_PERIOD + 2) begin
      cpu_read(kdf11_pkg::LKS_ADR, rd);
    end
    if (rd[7] !== 1'b1) begin
      n_timeouts++;
      $display("timeout: lks monitor bit not set again within one period");
    end

    // external routing, memory then unclaimed i/o then lks
    ext_word = 16'(lcg_next() >> 16);
    bus_request(22'(lcg_next() >> 10), 1'b0, 1'b0, 2'b11, 16'h0000);
    @(negedge clk_p);
    check_equal("ram_stb_o", 32'(ram_stb), 32'h1);
    check_equal("bus_stb_o", 32'(bus_stb), 32'h0);
    bus_complete(rd);
    check_equal("cpu_dat_o memory", 32'(rd), 32'(ext_word));
    ext_word = 16'(lcg_next() >> 16);
    bus_request(io_adr(16'o176500), 1'b1, 1'b0, 2'b11, 16'h0000);
    @(negedge clk_p);
    check_equal("bus_stb_o", 32'(bus_stb), 32'h1);
    check_equal("ram_stb_o", 32'(ram_stb), 32'h0);
    bus_complete(rd);
    check_equal("cpu_dat_o external", 32'(rd), 32'(ext_word));
    bus_request(io_adr(kdf11_pkg::LKS_ADR), 1'b1, 1'b0, 2'b11, 16'h0000);
    @(negedge clk_p);
    check_equal("bus_stb_o lks", 32'(bus_stb), 32'h0);
    check_equal("ram_stb_o lks", 32'(ram_stb), 32'h0);
    bus_complete(rd);

    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hw/kdf11_pkg.sv
hw/iopage_ctrl.sv
hw/ltc_timer.sv
hw/bdr_regs.sv
hw/umap_regs.sv
hw/kdf11_iopage.sv
tb/kdf11_iopage_asserts.sv
tb/tb_kdf11_iopage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_kdf11_iopage
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	grep -q "^STATUS: PASS$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
